/* project.f */
verilog/periph_pkg.sv
verilog/apb_slot_decode.sv
verilog/led_regs.sv
verilog/int_ctrl.sv
verilog/read_return.sv
verilog/periph_top.sv
tests/tb_periph_top.sv

/* tests/tb_periph_top.sv */
`timescale 1ns/10ps

module tb_periph_top;

	// roughly four times the length of the full run
	localparam int cycle_limit = 350;
	localparam logic [31:0] led_mask = (32'd1 << periph_pkg::led_w) - 32'd1;

	logic                            apb_clk;
	logic                            rst;
	logic                            req_valid;
	logic                            req_write;
	logic [periph_pkg::addr_w-1:0]   req_addr;
	logic [periph_pkg::data_w-1:0]   req_wdata;
	logic                            resp_valid;
	logic [periph_pkg::data_w-1:0]   resp_rdata;
	logic                            resp_err;
	logic [periph_pkg::irq_n-1:0]    irq_src;
	logic [periph_pkg::led_w-1:0]    led;
	logic                            int_o;

	integer seed;
	integer errors;
	integer checks;
	integer tests_run;
	integer cyc;
	// expected register contents
	logic [31:0] led_exp;
	logic [31:0] en_exp;

	periph_top UUT (
		.apb_clk	(apb_clk	),
		.rst		(rst		),
		.req_valid	(req_valid	),
		.req_write	(req_write	),
		.req_addr	(req_addr	),
		.req_wdata	(req_wdata	),
		.resp_valid	(resp_valid	),
		.resp_rdata	(resp_rdata	),
		.resp_err	(resp_err	),
		.irq_src	(irq_src	),
		.led		(led		),
		.int_o		(int_o		)
	);

	// 40 ns period
	always #20 apb_clk = ~apb_clk;

	// run limit
	always @(posedge apb_clk) begin
		cyc = cyc + 1;
		if (cyc >= cycle_limit) begin
			$display("timeout: run still going after %0d cycles", cyc);
			$display("Regression failed");
			$finish;
		end
	end

	// slot in bits 13..12, offset below
	function automatic logic [15:0] reg_addr(input logic [1:0] slot, input logic [11:0] off);
		logic [15:0] a;
		a = '0;
		a[periph_pkg::slot_lsb +: 2] = slot;
		a[periph_pkg::off_w-1:0] = off;
		return a;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		checks = checks + 1;
		assert (got === want) else begin
			$display("FAIL %s got %h expected %h", name, got, want);
			errors = errors + 1;
		end
	endtask

	task automatic drive_req(input logic write, input logic [15:0] addr,
		input logic [31:0] wdata);
		req_valid = 1'b1;
		req_write = write;
		req_addr = addr;
		req_wdata = wdata;
	endtask

	task automatic drive_idle;
		req_valid = 1'b0;
		req_write = 1'b0;
	endtask

	// write responses carry no defined data unless in error
	task automatic check_resp(input logic write, input logic [31:0] want_rdata,
		input logic want_err);
		checks = checks + 1;
		assert (resp_valid === 1'b1) else begin
			$display("response missing, resp_valid low when the response was due");
			errors = errors + 1;
		end
		check_value("resp_err", resp_err, want_err);
		if (!write || want_err) begin
			check_value("resp_rdata", resp_rdata, want_rdata);
		end
	endtask

	task automatic check_quiet;
		checks = checks + 1;
		assert (resp_valid === 1'b0) else begin
			$display("extra response, resp_valid high with no request due");
			errors = errors + 1;
		end
	endtask

	// one request, response two falling edges later
	task automatic access(input logic write, input logic [15:0] addr, input logic [31:0] wdata,
		input logic [31:0] want_rdata, input logic want_err);
		drive_req(write, addr, wdata);
		@(negedge apb_clk);
		drive_idle();
		check_quiet();
		@(negedge apb_clk);
		check_resp(write, want_rdata, want_err);
	endtask

	task automatic write_reg(input logic [15:0] addr, input logic [31:0] wdata,
		input logic want_err);
		access(1'b1, addr, wdata, 32'd0, want_err);
	endtask

	task automatic read_reg(input logic [15:0] addr, input logic [31:0] want_rdata,
		input logic want_err);
		access(1'b0, addr, 32'd0, want_rdata, want_err);
	endtask

	task automatic report_test(input string name, input integer errs_at_start);
		tests_run = tests_run + 1;
		if (errors == errs_at_start) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d errors", name, errors - errs_at_start);
		end
	endtask

	task automatic test_reset_state;
		integer e0;
		e0 = errors;
		check_value("led", led, 32'd0);
		check_value("int_o", int_o, 32'd0);
		check_value("resp_valid", resp_valid, 32'd0);
		read_reg(reg_addr(periph_pkg::slot_led, periph_pkg::reg_led_data), 32'd0, 1'b0);
		read_reg(reg_addr(periph_pkg::slot_int, periph_pkg::reg_int_pending), 32'd0, 1'b0);
		read_reg(reg_addr(periph_pkg::slot_int, periph_pkg::reg_int_enable), 32'd0, 1'b0);
		read_reg(reg_addr(periph_pkg::slot_int, periph_pkg::reg_int_raw), 32'd0, 1'b0);
		report_test("reset state", e0);
	endtask

	task automatic test_led_write;
		integer e0;
		logic [31:0] d;
		logic [15:0] led_a;
		e0 = errors;
		led_a = reg_addr(periph_pkg::slot_led, periph_pkg::reg_led_data);
		d = $random(seed);
		write_reg(led_a, d, 1'b0);
		led_exp = d & led_mask;
		check_value("led", led, led_exp);
		read_reg(led_a, led_exp, 1'b0);
		// write, read back, read enable on three strobes in a row
		d = $random(seed);
		drive_req(1'b1, led_a, d);
		@(negedge apb_clk);
		check_quiet();
		drive_req(1'b0, led_a, 32'd0);
		@(negedge apb_clk);
		check_resp(1'b1, 32'd0, 1'b0);
		drive_req(1'b0, reg_addr(periph_pkg::slot_int, periph_pkg::reg_int_enable), 32'd0);
		@(negedge apb_clk);
		led_exp = d & led_mask;
		check_resp(1'b0, led_exp, 1'b0);
		drive_idle();
		@(negedge apb_clk);
		check_resp(1'b0, 32'd0, 1'b0);
		@(negedge apb_clk);
		check_quiet();
		check_value("led", led, led_exp);
		report_test("led write", e0);
	endtask

	task automatic test_irq_pending;
		integer e0;
		logic [31:0] src_a;
		logic [31:0] src_b;
		e0 = errors;
		src_a = (32'd1 << periph_pkg::irq_uart0) | (32'd1 << periph_pkg::irq_dma);
		src_b = (32'd1 << periph_pkg::irq_spi) | (32'd1 << periph_pkg::irq_timer);
		// one cycle pulse
		irq_src = src_a[periph_pkg::irq_n-1:0];
		@(negedge apb_clk);
		irq_src = '0;
		@(negedge apb_clk);
		check_value("int_o", int_o, 32'd0);
		read_reg(reg_addr(periph_pkg::slot_int, periph_pkg::reg_int_pending), src_a, 1'b0);
		check_value("int_o", int_o, 32'd0);
		en_exp = 32'd1 << periph_pkg::irq_dma;
		write_reg(reg_addr(periph_pkg::slot_int, periph_pkg::reg_int_enable), en_exp, 1'b0);
		check_value("int_o", int_o, 32'd1);
		// raw levels while held
		irq_src = src_b[periph_pkg::irq_n-1:0];
		read_reg(reg_addr(periph_pkg::slot_int, periph_pkg::reg_int_raw), src_b, 1'b0);
		irq_src = '0;
		read_reg(reg_addr(periph_pkg::slot_int, periph_pkg::reg_int_pending),
			src_a | src_b, 1'b0);
		report_test("irq pending", e0);
	endtask

	task automatic test_irq_clear;
		integer e0;
		logic [31:0] hold;
		logic [31:0] pend_a;
		e0 = errors;
		hold = 32'd1 << periph_pkg::irq_flash;
		// left over from the pending test
		pend_a = (32'd1 << periph_pkg::irq_uart0) | (32'd1 << periph_pkg::irq_dma);
		check_value("int_o", int_o, 32'd1);
		irq_src = hold[periph_pkg::irq_n-1:0];
		write_reg(reg_addr(periph_pkg::slot_int, periph_pkg::reg_int_pending), pend_a, 1'b0);
		// dma gone, so nothing enabled is pending
		check_value("int_o", int_o, 32'd0);
		read_reg(reg_addr(periph_pkg::slot_int, periph_pkg::reg_int_pending), 32'h31, 1'b0);
		// flash stays while its source is high
		write_reg(reg_addr(periph_pkg::slot_int, periph_pkg::reg_int_pending), 32'h31, 1'b0);
		read_reg(reg_addr(periph_pkg::slot_int, periph_pkg::reg_int_pending), hold, 1'b0);
		irq_src = '0;
		write_reg(reg_addr(periph_pkg::slot_int, periph_pkg::reg_int_pending), hold, 1'b0);
		read_reg(reg_addr(periph_pkg::slot_int, periph_pkg::reg_int_pending), 32'd0, 1'b0);
		check_value("int_o", int_o, 32'd0);
		report_test("irq clear", e0);
	endtask

	task automatic test_bad_access;
		integer e0;
		e0 = errors;
		write_reg(reg_addr(periph_pkg::slot_led, periph_pkg::reg_led_data) | 16'd1,
			~led_exp, 1'b1);
		write_reg(reg_addr(2'd2, periph_pkg::reg_led_data), ~led_exp, 1'b1);
		read_reg(reg_addr(2'd3, 12'h004), 32'd0, 1'b1);
		write_reg(reg_addr(periph_pkg::slot_int, periph_pkg::reg_int_enable) | 16'd2,
			32'hff, 1'b1);
		read_reg(reg_addr(periph_pkg::slot_int, periph_pkg::reg_int_enable) | 16'd3,
			32'd0, 1'b1);
		// nothing above may land
		check_value("led", led, led_exp);
		read_reg(reg_addr(periph_pkg::slot_led, periph_pkg::reg_led_data), led_exp, 1'b0);
		read_reg(reg_addr(periph_pkg::slot_int, periph_pkg::reg_int_enable), en_exp, 1'b0);
		report_test("bad access", e0);
	endtask

	task automatic test_unknown_offset;
		integer e0;
		logic [31:0] pend_b;
		e0 = errors;
		pend_b = 32'd1 << periph_pkg::irq_i2c;
		read_reg(reg_addr(periph_pkg::slot_led, 12'h010), 32'd0, 1'b0);
		write_reg(reg_addr(periph_pkg::slot_led, 12'h010), ~led_exp, 1'b0);
		// live source, so raw and pending hold something to leak
		irq_src = pend_b[periph_pkg::irq_n-1:0];
		read_reg(reg_addr(periph_pkg::slot_int, 12'h00c), 32'd0, 1'b0);
		irq_src = '0;
		write_reg(reg_addr(periph_pkg::slot_int, 12'h00c), 32'hff, 1'b0);
		check_value("led", led, led_exp);
		read_reg(reg_addr(periph_pkg::slot_led, periph_pkg::reg_led_data), led_exp, 1'b0);
		read_reg(reg_addr(periph_pkg::slot_int, periph_pkg::reg_int_enable), en_exp, 1'b0);
		// i2c bit survives the write of ones
		read_reg(reg_addr(periph_pkg::slot_int, periph_pkg::reg_int_pending), pend_b, 1'b0);
		report_test("unknown offset", e0);
	endtask

	initial begin
		apb_clk = 1'b0;
		rst = 1'b1;
		req_valid = 1'b0;
		req_write = 1'b0;
		req_addr = '0;
		req_wdata = '0;
		irq_src = '0;
		seed = 11868;
		errors = 0;
		checks = 0;
		tests_run = 0;
		cyc = 0;
		led_exp = '0;
		en_exp = '0;
		// reset for 16 cycles, released on a falling edge
		repeat (16) @(negedge apb_clk);
		rst = 1'b0;
		@(negedge apb_clk);
		test_reset_state();
		test_led_write();
		test_irq_pending();
		test_irq_clear();
		test_bad_access();
		test_unknown_offset();
		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

/* verilog/periph_top.sv */
`timescale 1ns/10ps

module periph_top (
	input  logic                            apb_clk,
	input  logic                            rst,

	// register request from the bridge side
	input  logic                            req_valid,
	input  logic                            req_write,
	input  logic [periph_pkg::addr_w-1:0]   req_addr,
	input  logic [periph_pkg::data_w-1:0]   req_wdata,

	// response back to the bridge side
	output logic                            resp_valid,
	output logic [periph_pkg::data_w-1:0]   resp_rdata,
	output logic                            resp_err,

	input  logic [periph_pkg::irq_n-1:0]    irq_src,
	output logic [periph_pkg::led_w-1:0]    led,
	output logic                            int_o
);

	// decoded access
	logic                          acc_valid;
	logic                          acc_write;
	logic [periph_pkg::off_w-1:0]  acc_off;
	logic [periph_pkg::data_w-1:0] acc_wdata;
	logic [1:0]                    acc_slot;
	logic                          acc_err;
	logic                          led_sel;
	logic                          int_sel;

	// peripheral read data
	logic [periph_pkg::data_w-1:0] led_rdata;
	logic [periph_pkg::data_w-1:0] int_rdata;

	apb_slot_decode u_decode (
		.apb_clk	(apb_clk	),
		.rst		(rst		),
		.req_valid	(req_valid	),
		.req_write	(req_write	),
		.req_addr	(req_addr	),
		.req_wdata	(req_wdata	),
		.acc_valid	(acc_valid	),
		.acc_write	(acc_write	),
		.acc_off	(acc_off	),
		.acc_wdata	(acc_wdata	),
		.acc_slot	(acc_slot	),
		.acc_err	(acc_err	),
		.led_sel	(led_sel	),
		.int_sel	(int_sel	)
	);

	led_regs u_led (
		.apb_clk	(apb_clk	),
		.rst		(rst		),
		.led_sel	(led_sel	),
		.acc_write	(acc_write	),
		.acc_off	(acc_off	),
		.acc_wdata	(acc_wdata	),
		.led_rdata	(led_rdata	),
		.led		(led		)
	);

	// eight peripheral lines merged into int_o
	int_ctrl u_int (
		.apb_clk	(apb_clk	),
		.rst		(rst		),
		.int_sel	(int_sel	),
		.acc_write	(acc_write	),
		.acc_off	(acc_off	),
		.acc_wdata	(acc_wdata	),
		.irq_src	(irq_src	),
		.int_rdata	(int_rdata	),
		.int_o		(int_o		)
	);

	read_return u_return (
		.apb_clk	(apb_clk	),
		.rst		(rst		),
		.acc_valid	(acc_valid	),
		.acc_slot	(acc_slot	),
		.acc_err	(acc_err	),
		.led_rdata	(led_rdata	),
		.int_rdata	(int_rdata	),
		.resp_valid	(resp_valid	),
		.resp_rdata	(resp_rdata	),
		.resp_err	(resp_err	)
	);

endmodule

/* verilog/read_return.sv */
`timescale 1ns/10ps

module read_return (
	input  logic                            apb_clk,
	input  logic                            rst,

	input  logic                            acc_valid,
	input  logic [1:0]                      acc_slot,
	input  logic                            acc_err,

	input  logic [periph_pkg::data_w-1:0]   led_rdata,
	input  logic [periph_pkg::data_w-1:0]   int_rdata,

	output logic                            resp_valid,
	output logic [periph_pkg::data_w-1:0]   resp_rdata,
	output logic                            resp_err
);

	logic [periph_pkg::data_w-1:0] rdata_sel;

	// pick the addressed peripheral
	always_comb begin
		if (acc_err) begin
			// errors return zero
			rdata_sel = '0;
		end else begin
			case (acc_slot)
				periph_pkg::slot_led: rdata_sel = led_rdata;
				periph_pkg::slot_int: rdata_sel = int_rdata;
				default: rdata_sel = '0;
			endcase
		end
	end

	// response strobe and error flag
	always_ff @(posedge apb_clk) begin
		if (rst) begin
			resp_valid <= 1'b0;
			resp_err <= 1'b0;
		end else begin
			resp_valid <= acc_valid;
			resp_err <= acc_valid && acc_err;
		end
	end

	// response data
	always_ff @(posedge apb_clk) begin
		if (acc_valid) begin
			resp_rdata <= rdata_sel;
		end
	end

	// one response per access, one cycle later
	assert property (@(posedge apb_clk) disable iff (rst)
		resp_valid |-> $past(acc_valid))
		else $error("read_return: resp_valid without a preceding access");

endmodule

/* verilog/int_ctrl.sv */
`timescale 1ns/10ps

module int_ctrl (
	input  logic                            apb_clk,
	input  logic                            rst,

	input  logic                            int_sel,
	input  logic                            acc_write,
	input  logic [periph_pkg::off_w-1:0]    acc_off,
	input  logic [periph_pkg::data_w-1:0]   acc_wdata,

	input  logic [periph_pkg::irq_n-1:0]    irq_src,

	output logic [periph_pkg::data_w-1:0]   int_rdata,
	output logic                            int_o
);

	logic [periph_pkg::irq_n-1:0] pending;
	logic [periph_pkg::irq_n-1:0] enable;
	logic [periph_pkg::irq_n-1:0] clr_mask;
	logic                         wr_access;

	// write to this slot
	assign wr_access = int_sel && acc_write;

	// write one to clear
	assign clr_mask = (wr_access && (acc_off == periph_pkg::reg_int_pending)) ?
		acc_wdata[periph_pkg::irq_n-1:0] : '0;

	// pending bits
	// a live source sets its bit again in the same edge as a clear
	always_ff @(posedge apb_clk) begin
		if (rst) begin
			pending <= '0;
		end else begin
			pending <= (pending & ~clr_mask) | irq_src;
		end
	end

	// enable mask
	always_ff @(posedge apb_clk) begin
		if (rst) begin
			enable <= '0;
		end else if (wr_access && (acc_off == periph_pkg::reg_int_enable)) begin
			enable <= acc_wdata[periph_pkg::irq_n-1:0];
		end
	end

	// read mux by offset
	always_comb begin
		int_rdata = '0;
		case (acc_off)
			periph_pkg::reg_int_pending: int_rdata[periph_pkg::irq_n-1:0] = pending;
			periph_pkg::reg_int_enable: int_rdata[periph_pkg::irq_n-1:0] = enable;
			// sampled straight from the pins
			periph_pkg::reg_int_raw: int_rdata[periph_pkg::irq_n-1:0] = irq_src;
			default: int_rdata = '0;
		endcase
	end

	// merged cpu interrupt
	assign int_o = |(pending & enable);

	// masked sources never reach the cpu
	assert property (@(posedge apb_clk) disable iff (rst)
		(enable == '0) |-> !int_o)
		else $error("int_ctrl: int_o high with all sources masked");

endmodule

/* verilog/led_regs.sv */
`timescale 1ns/10ps

module led_regs (
	input  logic                            apb_clk,
	input  logic                            rst,

	input  logic                            led_sel,
	input  logic                            acc_write,
	input  logic [periph_pkg::off_w-1:0]    acc_off,
	input  logic [periph_pkg::data_w-1:0]   acc_wdata,

	output logic [periph_pkg::data_w-1:0]   led_rdata,
	output logic [periph_pkg::led_w-1:0]    led
);

	logic [periph_pkg::led_w-1:0] led_q;
	logic                         led_hit;
	logic                         led_we;

	// only one register in this slot
	assign led_hit = (acc_off == periph_pkg::reg_led_data);

	// write strobe for the led register
	assign led_we = led_sel && acc_write && led_hit;

	// led state, dark after reset
	always_ff @(posedge apb_clk) begin
		if (rst) begin
			led_q <= '0;
		end else if (led_we) begin
			// upper write bits are dropped
			led_q <= acc_wdata[periph_pkg::led_w-1:0];
		end
	end

	// readback
	// unknown offsets return zero
	always_comb begin
		led_rdata = '0;
		if (led_hit) begin
			led_rdata[periph_pkg::led_w-1:0] = led_q;
		end
	end

	// pins follow the register directly
	assign led = led_q;

endmodule

/* verilog/apb_slot_decode.sv */
`timescale 1ns/10ps

module apb_slot_decode (
	input  logic                            apb_clk,
	input  logic                            rst,

	input  logic                            req_valid,
	input  logic                            req_write,
	input  logic [periph_pkg::addr_w-1:0]   req_addr,
	input  logic [periph_pkg::data_w-1:0]   req_wdata,

	output logic                            acc_valid,
	output logic                            acc_write,
	output logic [periph_pkg::off_w-1:0]    acc_off,
	output logic [periph_pkg::data_w-1:0]   acc_wdata,
	output logic [1:0]                      acc_slot,
	output logic                            acc_err,

	output logic                            led_sel,
	output logic                            int_sel
);

	logic [1:0] req_slot;
	logic       req_misaligned;
	logic       req_unmapped;
	logic       req_bad;

	// slot number from the upper address field
	assign req_slot = req_addr[periph_pkg::slot_lsb +: 2];

	// word access only
	assign req_misaligned = |req_addr[1:0];

	// anything outside led and int slots
	assign req_unmapped = (req_slot != periph_pkg::slot_led) &&
		(req_slot != periph_pkg::slot_int);

	assign req_bad = req_misaligned || req_unmapped;

	// strobe, selects and error flag
	always_ff @(posedge apb_clk) begin
		if (rst) begin
			acc_valid <= 1'b0;
			acc_err <= 1'b0;
			led_sel <= 1'b0;
			int_sel <= 1'b0;
		end else begin
			acc_valid <= req_valid;
			acc_err <= req_valid && req_bad;
			// a bad access selects no peripheral
			led_sel <= req_valid && !req_bad && (req_slot == periph_pkg::slot_led);
			int_sel <= req_valid && !req_bad && (req_slot == periph_pkg::slot_int);
		end
	end

	// request payload
	// only captured on a strobe, the selects qualify it downstream
	always_ff @(posedge apb_clk) begin
		if (req_valid) begin
			acc_write <= req_write;
			acc_off <= req_addr[periph_pkg::off_w-1:0];
			acc_wdata <= req_wdata;
			acc_slot <= req_slot;
		end
	end

	// at most one peripheral per access, and only on a strobe
	assert property (@(posedge apb_clk) disable iff (rst)
		!(led_sel && int_sel) && ((led_sel || int_sel) -> acc_valid))
		else $error("apb_slot_decode: bad select combination");

endmodule

/* verilog/periph_pkg.sv */
package periph_pkg;

	// register bus widths
	localparam int unsigned addr_w = 16;
	localparam int unsigned data_w = 32;

	// slot field sits at address bits 13..12
	localparam int unsigned slot_lsb = 12;

	// mapped slots
	// slots 2 and 3 have no peripheral behind them
	localparam logic [1:0] slot_led = 2'd0;
	localparam logic [1:0] slot_int = 2'd1;

	// byte offset inside one slot
	localparam int unsigned off_w = 12;

	// led driver
	localparam int unsigned led_w = 4;
	localparam logic [off_w-1:0] reg_led_data = 12'h000;

	// interrupt controller registers
	localparam logic [off_w-1:0] reg_int_pending = 12'h000;
	localparam logic [off_w-1:0] reg_int_enable = 12'h004;
	// raw source levels, read only
	localparam logic [off_w-1:0] reg_int_raw = 12'h008;

	// interrupt source count
	localparam int unsigned irq_n = 8;

	// bit position of each source in irq_src
	localparam int unsigned irq_timer = 0;
	localparam int unsigned irq_i2c = 1;
	localparam int unsigned irq_uart1 = 2;
	// uart0 now arrives from outside like the rest
	localparam int unsigned irq_uart0 = 3;
	localparam int unsigned irq_flash = 4;
	localparam int unsigned irq_spi = 5;
	localparam int unsigned irq_vpwm = 6;
	localparam int unsigned irq_dma = 7;

endpackage
